//--- files.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/cpu_fetch.sv
rtl/cpu_queue.sv
rtl/cpu_registers.sv
rtl/cpu_execute.sv
rtl/cpu_core.sv
testbench/cpu_core_tb.sv

//--- rtl/cpu_bus_pkg.sv
package cpu_bus_pkg;

	// Data bus write request, held until ready
	typedef struct packed {
		logic        request;
		logic [31:0] address;
		logic [31:0] wdata;
	} dbus_req_t;

	// Fetched word and the address it came from
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
	} fetch_packet_t;

	// Control transfer from execute
	// valid flushes the queue and reloads the fetch PC
	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

endpackage

//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Instruction queue entries between fetch and execute
`define CPU_QUEUE_DEPTH 4

// First instruction address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- rtl/cpu_core.sv
`include "cpu_cfg.svh"

`timescale 1ns/1ns

module cpu_core
	import cpu_bus_pkg::*;
(
	input  logic i_clock,
	input  logic i_reset,

	// Instruction bus
	output logic o_ibus_request,
	input  logic i_ibus_ready,
	output logic [31:0] o_ibus_address,
	input  logic [31:0] i_ibus_rdata,

	// Data bus, writes only
	output logic o_dbus_rw,
	output logic o_dbus_request,
	input  logic i_dbus_ready,
	output logic [31:0] o_dbus_address,
	output logic [31:0] o_dbus_wdata,

	output logic [31:0] o_retire_count
);

	localparam int FREE_WIDTH = $clog2(`CPU_QUEUE_DEPTH + 1);

	redirect_t redirect;
	fetch_packet_t fetch_packet;
	logic fetch_push;
	fetch_packet_t head_packet;
	logic queue_empty;
	logic queue_full;
	logic [FREE_WIDTH-1:0] queue_free;
	logic queue_pop;
	logic [4:0] rs1_idx;
	logic [4:0] rs2_idx;
	logic [31:0] rs1;
	logic [31:0] rs2;
	logic rd_write;
	logic [4:0] rd_idx;
	logic [31:0] rd;
	dbus_req_t dbus;
	logic retire;

	//==================================================
	// FETCH

	cpu_fetch fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_redirect(redirect),
		.i_queue_free(queue_free),
		.o_ibus_request(o_ibus_request),
		.o_ibus_address(o_ibus_address),
		.i_ibus_ready(i_ibus_ready),
		.i_ibus_rdata(i_ibus_rdata),
		.o_push(fetch_push),
		.o_packet(fetch_packet)
	);

	//==================================================
	// QUEUE

	// Full is implied by the free count fetch reserves against
	cpu_queue #(
		.payload_t(fetch_packet_t),
		.depth(`CPU_QUEUE_DEPTH)
	) queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_flush(redirect.valid),
		.i_push(fetch_push && !queue_full),
		.i_data(fetch_packet),
		.i_pop(queue_pop),
		.o_data(head_packet),
		.o_empty(queue_empty),
		.o_full(queue_full),
		.o_free(queue_free)
	);

	//==================================================
	// EXECUTE

	cpu_execute execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_empty(queue_empty),
		.i_packet(head_packet),
		.o_pop(queue_pop),
		.o_rs1_idx(rs1_idx),
		.o_rs2_idx(rs2_idx),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rd_write(rd_write),
		.o_rd_idx(rd_idx),
		.o_rd(rd),
		.o_dbus(dbus),
		.i_dbus_ready(i_dbus_ready),
		.o_redirect(redirect),
		.o_retire(retire)
	);

	assign o_dbus_rw = 1'b1;
	assign o_dbus_request = dbus.request;
	assign o_dbus_address = dbus.address;
	assign o_dbus_wdata = dbus.wdata;

	//==================================================
	// REGISTERS

	cpu_registers registers (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_idx(rs1_idx),
		.i_rs2_idx(rs2_idx),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_write(rd_write),
		.i_rd_idx(rd_idx),
		.i_rd(rd)
	);

	//==================================================
	// RETIRE

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_retire_count <= 32'd0;
		else if (retire)
			o_retire_count <= o_retire_count + 32'd1;
	end

endmodule

//--- rtl/cpu_execute.sv
`timescale 1ns/1ns

module cpu_execute
	import cpu_isa_pkg::*, cpu_bus_pkg::*;
(
	input  logic i_clock,
	input  logic i_reset,

	// Queue head
	input  logic i_empty,
	input  fetch_packet_t i_packet,
	output logic o_pop,

	// Register file
	output logic [4:0] o_rs1_idx,
	output logic [4:0] o_rs2_idx,
	input  logic [31:0] i_rs1,
	input  logic [31:0] i_rs2,
	output logic o_rd_write,
	output logic [4:0] o_rd_idx,
	output logic [31:0] o_rd,

	// Data bus
	output dbus_req_t o_dbus,
	input  logic i_dbus_ready,

	output redirect_t o_redirect,
	output logic o_retire
);

	logic [31:0] insn;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	decoded_t dec;
	logic [31:0] operand_b;
	logic [31:0] alu_result;
	logic active;
	logic done;
	logic taken;

	assign insn = i_packet.instruction;
	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	//==================================================
	// Decode

	always_comb begin
		dec = '0;
		dec.rs1_idx = insn[19:15];
		dec.rs2_idx = insn[24:20];
		dec.rd_idx = insn[11:7];
		dec.alu_op = ALU_ADD;
		case (opcode)
			OPCODE_OP_IMM: begin
				dec.imm = {{20{insn[31]}}, insn[31:20]};
				dec.reg_write = (funct3 == FUNCT3_ADD_SUB);
			end
			OPCODE_OP: begin
				dec.reg_write = 1'b1;
				if (funct7 == FUNCT7_SUB && funct3 == FUNCT3_ADD_SUB)
					dec.alu_op = ALU_SUB;
				else if (funct7 != FUNCT7_BASE)
					dec.reg_write = 1'b0;
				else if (funct3 == FUNCT3_XOR)
					dec.alu_op = ALU_XOR;
				else if (funct3 == FUNCT3_OR)
					dec.alu_op = ALU_OR;
				else if (funct3 == FUNCT3_AND)
					dec.alu_op = ALU_AND;
				else if (funct3 != FUNCT3_ADD_SUB)
					dec.reg_write = 1'b0;
			end
			OPCODE_LUI: begin
				dec.imm = {insn[31:12], 12'd0};
				dec.alu_op = ALU_PASS;
				dec.reg_write = 1'b1;
			end
			OPCODE_STORE: begin
				dec.imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
				dec.store = (funct3 == FUNCT3_SW);
			end
			OPCODE_BRANCH: begin
				dec.imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
				dec.branch = (funct3 == FUNCT3_BEQ) || (funct3 == FUNCT3_BNE);
				dec.branch_ne = (funct3 == FUNCT3_BNE);
			end
			OPCODE_JAL: begin
				dec.imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
				dec.reg_write = 1'b1;
				dec.jump = 1'b1;
			end
			default: dec = dec;
		endcase
	end

	//==================================================
	// ALU and branch

	assign operand_b = (opcode == OPCODE_OP) ? i_rs2 : dec.imm;

	always_comb begin
		case (dec.alu_op)
			ALU_SUB: alu_result = i_rs1 - operand_b;
			ALU_AND: alu_result = i_rs1 & operand_b;
			ALU_OR: alu_result = i_rs1 | operand_b;
			ALU_XOR: alu_result = i_rs1 ^ operand_b;
			ALU_PASS: alu_result = operand_b;
			default: alu_result = i_rs1 + operand_b;
		endcase
	end

	assign taken = dec.jump || (dec.branch && ((i_rs1 == i_rs2) != dec.branch_ne));

	//==================================================
	// Completion

	// Anything but a store finishes the cycle it reaches the head
	assign active = !i_empty;
	assign done = active && (!dec.store || i_dbus_ready);

	assign o_pop = done;
	assign o_rs1_idx = dec.rs1_idx;
	assign o_rs2_idx = dec.rs2_idx;
	assign o_rd_write = done && dec.reg_write;
	assign o_rd_idx = dec.rd_idx;
	assign o_rd = dec.jump ? i_packet.pc + 32'd4 : alu_result;

	assign o_dbus = '{request: active && dec.store, address: alu_result, wdata: i_rs2};
	assign o_redirect = '{valid: active && taken, target: i_packet.pc + dec.imm};

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_retire <= 1'b0;
		else
			o_retire <= done;
	end

endmodule

//--- rtl/cpu_fetch.sv
`include "cpu_cfg.svh"

`timescale 1ns/1ns

module cpu_fetch
	import cpu_bus_pkg::*;
(
	input  logic i_clock,
	input  logic i_reset,

	input  redirect_t i_redirect,
	input  logic [$clog2(`CPU_QUEUE_DEPTH + 1)-1:0] i_queue_free,

	// Instruction bus
	output logic o_ibus_request,
	output logic [31:0] o_ibus_address,
	input  logic i_ibus_ready,
	input  logic [31:0] i_ibus_rdata,

	// Queue push
	output logic o_push,
	output fetch_packet_t o_packet
);

	localparam int FREE_WIDTH = $clog2(`CPU_QUEUE_DEPTH + 1);

	logic [31:0] pc;
	logic discard;
	logic bus_done;
	logic issue;
	logic [FREE_WIDTH-1:0] pending;

	assign bus_done = o_ibus_request && i_ibus_ready;

	// Words not yet in the queue count: the registered push and the open request
	assign pending = FREE_WIDTH'(o_push) + FREE_WIDTH'(o_ibus_request);

	// Bus is free next cycle and the queue has a slot for one more word
	assign issue = (!o_ibus_request || i_ibus_ready) && !i_redirect.valid &&
		(i_queue_free > pending);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= `CPU_RESET_PC;
			discard <= 1'b0;
			o_ibus_request <= 1'b0;
			o_push <= 1'b0;
		end
		else begin
			o_push <= bus_done && !discard && !i_redirect.valid;

			if (bus_done)
				discard <= 1'b0;

			if (i_redirect.valid) begin
				pc <= i_redirect.target;
				// Request in flight finishes on the bus but its word is dropped
				if (o_ibus_request && !i_ibus_ready)
					discard <= 1'b1;
			end
			else if (issue) begin
				pc <= pc + 32'd4;
			end

			if (issue)
				o_ibus_request <= 1'b1;
			else if (bus_done)
				o_ibus_request <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (issue)
			o_ibus_address <= pc;
		if (bus_done)
			o_packet <= '{pc: o_ibus_address, instruction: i_ibus_rdata};
	end

endmodule

//--- rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// Major opcodes
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
	localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
	localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

	// funct3 values of the supported encodings
	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;
	localparam logic [2:0] FUNCT3_SW      = 3'b010;
	localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
	localparam logic [2:0] FUNCT3_BNE     = 3'b001;

	// funct7 values
	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS
	} alu_op_t;

	// All flags low means the word retires as a no-op
	typedef struct packed {
		logic [4:0]  rs1_idx;
		logic [4:0]  rs2_idx;
		logic [4:0]  rd_idx;
		logic [31:0] imm;
		alu_op_t     alu_op;
		logic        reg_write;
		logic        store;
		logic        branch;
		logic        branch_ne;
		logic        jump;
	} decoded_t;

endpackage

//--- rtl/cpu_queue.sv
`timescale 1ns/1ns

module cpu_queue #(
	parameter type payload_t = logic [31:0],
	parameter int depth = 4
) (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_flush,

	input  logic i_push,
	input  payload_t i_data,

	input  logic i_pop,
	output payload_t o_data,

	output logic o_empty,
	output logic o_full,
	output logic [$clog2(depth + 1)-1:0] o_free
);

	localparam int PTR_WIDTH = $clog2(depth);
	localparam int COUNT_WIDTH = $clog2(depth + 1);

	payload_t entries [depth];
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	assign o_empty = (count == '0);
	assign o_full = (count == COUNT_WIDTH'(depth));
	assign o_free = COUNT_WIDTH'(depth) - count;
	assign o_data = entries[rd_ptr];

	// Flush wins over push and pop
	always_ff @(posedge i_clock) begin
		if (i_reset || i_flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push)
			entries[wr_ptr] <= i_data;
	end

endmodule

//--- rtl/cpu_registers.sv
`timescale 1ns/1ns

module cpu_registers (
	input  logic i_clock,
	input  logic i_reset,

	// Read ports
	input  logic [4:0] i_rs1_idx,
	input  logic [4:0] i_rs2_idx,
	output logic [31:0] o_rs1,
	output logic [31:0] o_rs2,

	// Write port
	input  logic i_write,
	input  logic [4:0] i_rd_idx,
	input  logic [31:0] i_rd
);

	// x0 has no storage
	logic [31:0] regs [1:31];

	assign o_rs1 = (i_rs1_idx == 5'd0) ? 32'd0 : regs[i_rs1_idx];
	assign o_rs2 = (i_rs2_idx == 5'd0) ? 32'd0 : regs[i_rs2_idx];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'd0;
		end
		else if (i_write && i_rd_idx != 5'd0) begin
			regs[i_rd_idx] <= i_rd;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
	-f files.f --top-module cpu_core_tb \
	--Mdir obj_dir -o cpu_core_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/cpu_core_sim

//--- testbench/cpu_core_tb.sv
`include "cpu_cfg.svh"

`timescale 1ns/1ns

module cpu_core_tb
	import cpu_isa_pkg::*;
();

	logic i_clock;
	logic i_reset;
	logic o_ibus_request;
	logic i_ibus_ready;
	logic [31:0] o_ibus_address;
	logic [31:0] i_ibus_rdata;
	logic o_dbus_rw;
	logic o_dbus_request;
	logic i_dbus_ready;
	logic [31:0] o_dbus_address;
	logic [31:0] o_dbus_wdata;
	logic [31:0] o_retire_count;

	logic [31:0] imem [64];
	int n_insns;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int exp_order [$];
	int expected_retires;
	int store_idx;
	int cycles;
	int timeout_limit;
	integer seed;
	logic models_on;

	// Bus model state from the previous cycle
	logic ibus_last_req;
	logic [31:0] ibus_last_addr;
	int ibus_wait;
	logic dbus_last_req;
	logic [31:0] dbus_last_addr;
	logic [31:0] dbus_last_data;
	logic dbus_last_done;
	int dbus_wait;

	cpu_core UUT (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(i_ibus_rdata),
		.o_dbus_rw(o_dbus_rw),
		.o_dbus_request(o_dbus_request),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.o_dbus_wdata(o_dbus_wdata),
		.o_retire_count(o_retire_count)
	);

	always #4 i_clock = ~i_clock;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
			else fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
	endtask

	//==================================================
	// Instruction encoders and program image

	function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OPCODE_OP};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, FUNCT3_ADD_SUB, rd, OPCODE_OP_IMM};
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OPCODE_LUI};
	endfunction

	function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, FUNCT3_SW, imm[4:0], OPCODE_STORE};
	endfunction

	function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[n_insns] = word;
		n_insns++;
	endtask

	task automatic load_program();
		// Unused words hold custom-0 encodings tagged with their index
		for (int i = 0; i < 64; i++)
			imem[i] = {i[24:0], 7'h0b};
		n_insns = 0;
		emit(lui(5'd10, 20'h00001));
		emit(addi(5'd1, 5'd0, 12'd5));
		emit(addi(5'd2, 5'd0, -12'd3));
		emit(op_reg(FUNCT7_BASE, FUNCT3_ADD_SUB, 5'd3, 5'd1, 5'd2));
		emit(op_reg(FUNCT7_SUB, FUNCT3_ADD_SUB, 5'd4, 5'd1, 5'd2));
		emit(lui(5'd5, 20'h12345));
		emit(op_reg(FUNCT7_BASE, FUNCT3_XOR, 5'd6, 5'd5, 5'd2));
		emit(op_reg(FUNCT7_BASE, FUNCT3_OR, 5'd7, 5'd5, 5'd1));
		emit(op_reg(FUNCT7_BASE, FUNCT3_AND, 5'd8, 5'd6, 5'd2));
		emit(addi(5'd0, 5'd1, 12'd7));
		emit(sw(5'd3, 5'd10, 12'd0));
		emit(sw(5'd4, 5'd10, 12'd4));
		emit(sw(5'd6, 5'd10, 12'd8));
		emit(sw(5'd7, 5'd10, 12'd12));
		emit(sw(5'd8, 5'd10, 12'd16));
		emit(sw(5'd0, 5'd10, 12'd20));
		// EBREAK is outside the supported set
		emit(32'h0010_0073);
		emit(branch(FUNCT3_BEQ, 5'd1, 5'd1, 13'd8));
		emit(sw(5'd1, 5'd10, 12'd24));
		emit(branch(FUNCT3_BNE, 5'd1, 5'd2, 13'd8));
		emit(sw(5'd2, 5'd10, 12'd28));
		emit(branch(FUNCT3_BEQ, 5'd1, 5'd2, 13'd8));
		emit(branch(FUNCT3_BNE, 5'd1, 5'd1, 13'd8));
		emit(jal(5'd11, 21'd8));
		emit(sw(5'd1, 5'd10, 12'd32));
		emit(sw(5'd11, 5'd10, 12'd36));
		emit(op_reg(FUNCT7_SUB, FUNCT3_ADD_SUB, 5'd12, 5'd11, 5'd4));
		emit(sw(5'd12, 5'd10, 12'd40));
		emit(jal(5'd0, 21'd0));
	endtask

	//==================================================
	// Reference model, stepping in program order

	task automatic run_model();
		logic [31:0] x [32];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] next_pc;
		logic [4:0] rd;
		logic stop;
		for (int i = 0; i < 32; i++)
			x[i] = 32'd0;
		pc = `CPU_RESET_PC;
		stop = 1'b0;
		expected_retires = 0;
		while (!stop && expected_retires < 1000) begin
			w = imem[pc[7:2]];
			a = x[w[19:15]];
			b = x[w[24:20]];
			rd = w[11:7];
			next_pc = pc + 32'd4;
			expected_retires++;
			case (w[6:0])
				OPCODE_OP_IMM: begin
					if (w[14:12] == FUNCT3_ADD_SUB)
						x[rd] = a + {{20{w[31]}}, w[31:20]};
				end
				OPCODE_OP: begin
					case ({w[31:25], w[14:12]})
						{FUNCT7_BASE, FUNCT3_ADD_SUB}: x[rd] = a + b;
						{FUNCT7_SUB, FUNCT3_ADD_SUB}: x[rd] = a - b;
						{FUNCT7_BASE, FUNCT3_XOR}: x[rd] = a ^ b;
						{FUNCT7_BASE, FUNCT3_OR}: x[rd] = a | b;
						{FUNCT7_BASE, FUNCT3_AND}: x[rd] = a & b;
						default: ;
					endcase
				end
				OPCODE_LUI: x[rd] = {w[31:12], 12'd0};
				OPCODE_STORE: begin
					if (w[14:12] == FUNCT3_SW) begin
						exp_addr.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
						exp_data.push_back(b);
						exp_order.push_back(expected_retires - 1);
					end
				end
				OPCODE_BRANCH: begin
					if ((w[14:12] == FUNCT3_BEQ && a == b) || (w[14:12] == FUNCT3_BNE && a != b))
						next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
				OPCODE_JAL: begin
					x[rd] = pc + 32'd4;
					next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
					// Jump to itself ends the program
					stop = (next_pc == pc);
				end
				default: ;
			endcase
			x[0] = 32'd0;
			pc = next_pc;
		end
	endtask

	//==================================================
	// Bus models with random ready delays

	task automatic record_store();
		assert (store_idx < exp_addr.size())
			else fail_run("Store seen on the data bus after the last expected store");
		check_value($sformatf("store %0d rw", store_idx), 32'd1, 32'(o_dbus_rw));
		check_value($sformatf("store %0d address", store_idx), exp_addr[store_idx], o_dbus_address);
		check_value($sformatf("store %0d data", store_idx), exp_data[store_idx], o_dbus_wdata);
		store_idx++;
	endtask

	// Both buses in one block so the random sequence is fixed
	always @(posedge i_clock) begin
		#1;
		if (models_on) begin
			if (ibus_last_req && !i_ibus_ready) begin
				assert (o_ibus_request && o_ibus_address == ibus_last_addr)
					else fail_run("Instruction bus request or address changed before ready");
			end
			else if (o_ibus_request) begin
				ibus_wait = $unsigned($random(seed)) % 4;
			end
			i_ibus_ready = o_ibus_request && ibus_wait == 0;
			i_ibus_rdata = i_ibus_ready ? imem[o_ibus_address[7:2]] : 32'd0;
			if (o_ibus_request && ibus_wait != 0)
				ibus_wait--;
			ibus_last_req = o_ibus_request;
			ibus_last_addr = o_ibus_address;

			// Count seen one cycle after a store holds everything before it
			if (dbus_last_done)
				check_value($sformatf("retired before store %0d", store_idx - 1),
					32'(exp_order[store_idx - 1]), o_retire_count);
			if (dbus_last_req && !i_dbus_ready) begin
				assert (o_dbus_request && o_dbus_address == dbus_last_addr &&
					o_dbus_wdata == dbus_last_data)
					else fail_run("Data bus request, address or data changed before ready");
			end
			else if (o_dbus_request) begin
				dbus_wait = $unsigned($random(seed)) % 4;
			end
			i_dbus_ready = o_dbus_request && dbus_wait == 0;
			if (o_dbus_request && dbus_wait != 0)
				dbus_wait--;
			dbus_last_done = i_dbus_ready;
			if (i_dbus_ready)
				record_store();
			dbus_last_req = o_dbus_request;
			dbus_last_addr = o_dbus_address;
			dbus_last_data = o_dbus_wdata;
		end
	end

	always @(posedge i_clock) begin
		cycles++;
		if (cycles > timeout_limit)
			fail_run($sformatf("Timeout after %0d cycles before the expected retire count", cycles));
	end

	//==================================================
	// Main sequence

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_ibus_ready = 1'b0;
		i_ibus_rdata = 32'd0;
		i_dbus_ready = 1'b0;
		seed = 32;
		models_on = 1'b0;
		ibus_last_req = 1'b0;
		ibus_last_addr = 32'd0;
		ibus_wait = 0;
		dbus_last_req = 1'b0;
		dbus_last_addr = 32'd0;
		dbus_last_data = 32'd0;
		dbus_last_done = 1'b0;
		dbus_wait = 0;
		store_idx = 0;
		cycles = 0;
		load_program();
		run_model();
		timeout_limit = 40 * n_insns + 200;

		repeat (16) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		@(negedge i_clock);
		check_value("reset ibus request", 32'd0, 32'(o_ibus_request));
		check_value("reset dbus request", 32'd0, 32'(o_dbus_request));
		check_value("reset retire count", 32'd0, o_retire_count);
		models_on = 1'b1;

		// First fetch goes out in the first cycle after reset
		@(posedge i_clock);
		#1;
		check_value("first fetch request", 32'd1, 32'(o_ibus_request));
		check_value("first fetch address", `CPU_RESET_PC, o_ibus_address);

		wait (o_retire_count == 32'(expected_retires));
		@(negedge i_clock);
		if (store_idx == exp_addr.size()) begin
			$display("=== PASS ===");
			$finish;
		end
		else begin
			fail_run($sformatf("MISMATCH store count: expected %0d, actual %0d",
				exp_addr.size(), store_idx));
		end
	end

endmodule
